/* hdl/fetch_pkg.sv */
package fetch_pkg;

    // Basic widths of the fetch stage
    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;

    // Four words per line, word 0 at the lowest address
    typedef logic [3:0][31:0] line_t;

    // Mispredict, jump and trap return all use this
    typedef struct packed {
        logic valid;
        pc_t  target;
    } redirect_t;

    // Training record from execute
    typedef struct packed {
        logic valid;
        logic taken;
        pc_t  pc;
        pc_t  target;
    } bp_update_t;

    // Read request, address is line aligned
    typedef struct packed {
        logic req;
        pc_t  addr;
    } mem_req_t;

    // addi x0,x0,0
    parameter instr_t NOP_INSTR = 32'h0000_0013;

    parameter logic [6:0] OPC_BRANCH = 7'b1100011;

    parameter pc_t RESET_PC = 32'h0000_0000;

endpackage

/* hdl/pc_gen.sv */
`timescale 1ns/10ps

module pc_gen (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  advance_i,
    input  logic                  pred_taken_i,
    input  fetch_pkg::pc_t        pred_target_i,
    input  fetch_pkg::redirect_t  mispredict_i,
    input  fetch_pkg::redirect_t  jump_i,
    input  fetch_pkg::redirect_t  trap_ret_i,
    output fetch_pkg::pc_t        pc_o
);

    fetch_pkg::pc_t pc_q;
    fetch_pkg::pc_t pc_d;
    fetch_pkg::pc_t pc_seq;

    assign pc_seq = pc_q + 32'd4;

    // Redirects win over everything, even a stall
    always_comb begin
        if (mispredict_i.valid) begin
            pc_d = mispredict_i.target;
        end else if (jump_i.valid) begin
            pc_d = jump_i.target;
        end else if (trap_ret_i.valid) begin
            pc_d = trap_ret_i.target;
        end else if (advance_i) begin
            if (pred_taken_i) begin
                pc_d = pred_target_i;
            end else begin
                pc_d = pc_seq;
            end
        end else begin
            // Stall or miss
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

/* hdl/branch_predictor.sv */
`timescale 1ns/10ps

module branch_predictor #(
    parameter int BHT_ENTRIES = 32
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  fetch_pkg::pc_t         pc_i,
    input  fetch_pkg::instr_t      instr_i,
    input  logic                   hit_i,
    input  fetch_pkg::bp_update_t  update_i,
    output logic                   pred_taken_o,
    output fetch_pkg::pc_t         pred_target_o
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);
    localparam int TAG_W = 32 - IDX_W - 2;

    logic [1:0]       cnt_q      [BHT_ENTRIES];
    logic [TAG_W-1:0] btb_tag_q  [BHT_ENTRIES];
    fetch_pkg::pc_t   btb_tgt_q  [BHT_ENTRIES];
    logic [BHT_ENTRIES-1:0] btb_valid_q;

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             is_branch;
    logic             btb_match;

    assign rd_idx = pc_i[IDX_W+1:2];
    assign rd_tag = pc_i[31:IDX_W+2];
    assign wr_idx = update_i.pc[IDX_W+1:2];
    assign wr_tag = update_i.pc[31:IDX_W+2];

    // Predecode, only conditional branches are predicted
    assign is_branch = (instr_i[6:0] == fetch_pkg::OPC_BRANCH);

    assign btb_match = btb_valid_q[rd_idx] && (btb_tag_q[rd_idx] == rd_tag);

    assign pred_taken_o  = hit_i && is_branch && cnt_q[rd_idx][1] && btb_match;
    assign pred_target_o = btb_tgt_q[rd_idx];

    // Saturating 2-bit counters, start weakly not taken
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                cnt_q[i] <= 2'b01;
            end
        end else if (update_i.valid) begin
            if (update_i.taken) begin
                if (cnt_q[wr_idx] != 2'b11) begin
                    cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'b01;
                end
            end else begin
                if (cnt_q[wr_idx] != 2'b00) begin
                    cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'b01;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            btb_valid_q <= '0;
        end else if (update_i.valid && update_i.taken) begin
            btb_valid_q[wr_idx] <= 1'b1;
        end
    end

    // Target buffer payload
    always_ff @(posedge clk_i) begin
        if (update_i.valid && update_i.taken) begin
            btb_tag_q[wr_idx] <= wr_tag;
            btb_tgt_q[wr_idx] <= update_i.target;
        end
    end

endmodule

/* hdl/icache.sv */
`timescale 1ns/10ps

module icache #(
    parameter int ICACHE_LINES = 16
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  fetch_pkg::pc_t     pc_i,
    input  logic               fill_i,
    input  fetch_pkg::pc_t     fill_addr_i,
    input  fetch_pkg::line_t   fill_line_i,
    output logic               hit_o,
    output fetch_pkg::instr_t  instr_o
);

    // 16 byte lines, so 4 offset bits
    localparam int OFF_W = 4;
    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = 32 - IDX_W - OFF_W;

    logic [ICACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q  [ICACHE_LINES];
    fetch_pkg::line_t        line_q [ICACHE_LINES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    fetch_pkg::line_t rd_line;

    assign rd_idx = pc_i[IDX_W+OFF_W-1:OFF_W];
    assign rd_tag = pc_i[31:IDX_W+OFF_W];
    assign wr_idx = fill_addr_i[IDX_W+OFF_W-1:OFF_W];
    assign wr_tag = fill_addr_i[31:IDX_W+OFF_W];

    // Lookup
    assign rd_line = line_q[rd_idx];
    assign hit_o   = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign instr_o = rd_line[pc_i[3:2]];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[wr_idx]  <= wr_tag;
            line_q[wr_idx] <= fill_line_i;
        end
    end

endmodule

/* hdl/icache_ctrl.sv */
`timescale 1ns/10ps

module icache_ctrl #(
    parameter int ICACHE_LINES = 16
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  fetch_pkg::pc_t       pc_i,
    input  logic                 hit_i,
    input  logic                 mem_ready_i,
    input  logic                 mem_valid_i,
    input  fetch_pkg::line_t     mem_line_i,
    output fetch_pkg::mem_req_t  mem_req_o,
    output logic                 fill_o,
    output fetch_pkg::pc_t       fill_addr_o,
    output fetch_pkg::line_t     fill_line_o,
    output logic                 ready_o
);

    localparam int OFF_W = 4;
    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = 32 - IDX_W - OFF_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t state_q;
    state_t state_d;

    // Line being fetched, kept as tag and index
    logic [TAG_W-1:0] miss_tag_q;
    logic [IDX_W-1:0] miss_idx_q;
    logic             start_miss;

    assign start_miss = (state_q == ST_IDLE) && !hit_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (!hit_i) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                // Accepted this cycle, req drops next cycle
                if (mem_ready_i) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (mem_valid_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address is frozen for the whole miss, even across a redirect
    always_ff @(posedge clk_i) begin
        if (start_miss) begin
            miss_tag_q <= pc_i[31:IDX_W+OFF_W];
            miss_idx_q <= pc_i[IDX_W+OFF_W-1:OFF_W];
        end
    end

    assign mem_req_o.req  = (state_q == ST_REQ);
    assign mem_req_o.addr = {miss_tag_q, miss_idx_q, {OFF_W{1'b0}}};

    // Fill on the edge the line arrives
    assign fill_o      = (state_q == ST_WAIT) && mem_valid_i;
    assign fill_addr_o = {miss_tag_q, miss_idx_q, {OFF_W{1'b0}}};
    assign fill_line_o = mem_line_i;

    assign ready_o = hit_i && (state_q == ST_IDLE);

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage #(
    parameter int ICACHE_LINES = 16,
    parameter int BHT_ENTRIES  = 32
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   stall_i,
    input  fetch_pkg::redirect_t   mispredict_i,
    input  fetch_pkg::redirect_t   jump_i,
    input  fetch_pkg::redirect_t   trap_ret_i,
    input  fetch_pkg::bp_update_t  bp_update_i,
    input  logic                   mem_ready_i,
    input  logic                   mem_valid_i,
    input  fetch_pkg::line_t       mem_line_i,
    output fetch_pkg::mem_req_t    mem_req_o,
    output fetch_pkg::pc_t         pc_o,
    output fetch_pkg::instr_t      instr_o,
    output logic                   pred_taken_o
);

    // Stage output bundle
    typedef struct packed {
        fetch_pkg::pc_t    pc;
        fetch_pkg::instr_t instr;
        logic              pred_taken;
    } fetch_out_t;

    fetch_pkg::pc_t    pc_q;
    fetch_pkg::pc_t    pred_target;
    fetch_pkg::pc_t    fill_addr;
    fetch_pkg::line_t  fill_line;
    fetch_pkg::instr_t hit_word;
    logic              hit;
    logic              pred_taken;
    logic              fill;
    logic              ready;
    logic              advance;
    logic              redirect;
    fetch_out_t        out_q;

    assign redirect = mispredict_i.valid || jump_i.valid || trap_ret_i.valid;
    assign advance  = ready && !stall_i;

    pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .advance_i     (advance),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .mispredict_i  (mispredict_i),
        .jump_i        (jump_i),
        .trap_ret_i    (trap_ret_i),
        .pc_o          (pc_q)
    );

    branch_predictor #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) u_branch_predictor (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .pc_i          (pc_q),
        .instr_i       (hit_word),
        .hit_i         (hit),
        .update_i      (bp_update_i),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    icache #(
        .ICACHE_LINES (ICACHE_LINES)
    ) u_icache (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .pc_i        (pc_q),
        .fill_i      (fill),
        .fill_addr_i (fill_addr),
        .fill_line_i (fill_line),
        .hit_o       (hit),
        .instr_o     (hit_word)
    );

    icache_ctrl #(
        .ICACHE_LINES (ICACHE_LINES)
    ) u_icache_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .pc_i        (pc_q),
        .hit_i       (hit),
        .mem_ready_i (mem_ready_i),
        .mem_valid_i (mem_valid_i),
        .mem_line_i  (mem_line_i),
        .mem_req_o   (mem_req_o),
        .fill_o      (fill),
        .fill_addr_o (fill_addr),
        .fill_line_o (fill_line),
        .ready_o     (ready)
    );

    // Output register; pc is kept while a bubble is emitted
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q.pc         <= '0;
            out_q.instr      <= fetch_pkg::NOP_INSTR;
            out_q.pred_taken <= 1'b0;
        end else if (redirect) begin
            out_q.instr      <= fetch_pkg::NOP_INSTR;
            out_q.pred_taken <= 1'b0;
        end else if (!stall_i) begin
            if (ready) begin
                out_q.pc         <= pc_q;
                out_q.instr      <= hit_word;
                out_q.pred_taken <= pred_taken;
            end else begin
                out_q.instr      <= fetch_pkg::NOP_INSTR;
                out_q.pred_taken <= 1'b0;
            end
        end
    end

    assign pc_o         = out_q.pc;
    assign instr_o      = out_q.instr;
    assign pred_taken_o = out_q.pred_taken;

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* verif/mem_model.sv */
`timescale 1ns/10ps

module mem_model #(
    parameter fetch_pkg::pc_t BR_A = 32'h0000_0024,
    parameter fetch_pkg::pc_t BR_B = 32'h0000_0148
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  fetch_pkg::mem_req_t  req_i,
    output logic                 ready_o,
    output logic                 valid_o,
    output fetch_pkg::line_t     line_o,
    output logic                 acc_o,
    output fetch_pkg::pc_t       acc_addr_o
);

    logic           busy;
    int             delay;
    fetch_pkg::pc_t addr_q;

    // Branches at two addresses and plain ALU words elsewhere
    function automatic fetch_pkg::instr_t pattern(input fetch_pkg::pc_t a);
        if (a == BR_A || a == BR_B) begin
            return {a[26:2], fetch_pkg::OPC_BRANCH};
        end
        return {a[26:2] ^ {18'd0, a[31:27], a[1:0]} ^ 25'h1b4_e27, 7'b0110011};
    endfunction

    initial begin
        ready_o    = 1'b0;
        valid_o    = 1'b0;
        line_o     = '0;
        acc_o      = 1'b0;
        acc_addr_o = '0;
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_o    <= 1'b0;
            valid_o    <= 1'b0;
            line_o     <= '0;
            acc_o      <= 1'b0;
            acc_addr_o <= '0;
            busy       <= 1'b0;
            delay      <= 0;
            addr_q     <= '0;
        end else begin
            acc_o   <= 1'b0;
            valid_o <= 1'b0;
            if (!busy) begin
                if (req_i.req && ready_o) begin
                    busy       <= 1'b1;
                    addr_q     <= req_i.addr;
                    delay      <= 2 + ($urandom % 5);
                    ready_o    <= 1'b0;
                    acc_o      <= 1'b1;
                    acc_addr_o <= req_i.addr;
                end else begin
                    ready_o <= ($urandom % 3) != 0;
                end
            end else if (delay > 1) begin
                delay <= delay - 1;
            end else begin
                valid_o <= 1'b1;
                line_o  <= {pattern(addr_q + 32'd12), pattern(addr_q + 32'd8),
                            pattern(addr_q + 32'd4), pattern(addr_q)};
                busy    <= 1'b0;
            end
        end
    end

endmodule

/* verif/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb;

    localparam fetch_pkg::pc_t BR_A = 32'h0000_0024;
    localparam fetch_pkg::pc_t BR_B = 32'h0000_0148;
    localparam int LINES      = 16;
    localparam int WAIT_LIMIT = 300;

    typedef struct packed {
        fetch_pkg::pc_t    pc;
        fetch_pkg::instr_t instr;
        logic              pred;
    } out_t;

    logic                  clk;
    logic                  arst_n;
    logic                  stall;
    fetch_pkg::redirect_t  mispredict;
    fetch_pkg::redirect_t  jump;
    fetch_pkg::redirect_t  trap_ret;
    fetch_pkg::bp_update_t bp_update;
    logic                  mem_ready;
    logic                  mem_valid;
    fetch_pkg::line_t      mem_line;
    fetch_pkg::mem_req_t   mem_req;
    fetch_pkg::pc_t        pc_out;
    fetch_pkg::instr_t     instr_out;
    logic                  pred_out;
    logic                  acc;
    fetch_pkg::pc_t        acc_addr;

    // Reference state
    logic [1:0]            ref_cnt [2];
    logic                  ref_btb [2];
    fetch_pkg::pc_t        ref_tgt [2];
    logic                  res_valid [LINES];
    fetch_pkg::pc_t        res_line [LINES];
    fetch_pkg::pc_t        exp_pc;
    fetch_pkg::pc_t        last_pc;
    out_t                  exp_out;
    out_t                  held;
    logic                  pr_stall;
    fetch_pkg::redirect_t  pr_redir;
    fetch_pkg::bp_update_t pr_upd;
    int                    checked;
    int                    slot;
    int                    idx;
    int                    n;

    clk_gen u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    mem_model #(
        .BR_A (BR_A),
        .BR_B (BR_B)
    ) u_mem_model (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .req_i      (mem_req),
        .ready_o    (mem_ready),
        .valid_o    (mem_valid),
        .line_o     (mem_line),
        .acc_o      (acc),
        .acc_addr_o (acc_addr)
    );

    fetch_stage #(
        .ICACHE_LINES (LINES),
        .BHT_ENTRIES  (32)
    ) UUT (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .stall_i      (stall),
        .mispredict_i (mispredict),
        .jump_i       (jump),
        .trap_ret_i   (trap_ret),
        .bp_update_i  (bp_update),
        .mem_ready_i  (mem_ready),
        .mem_valid_i  (mem_valid),
        .mem_line_i   (mem_line),
        .mem_req_o    (mem_req),
        .pc_o         (pc_out),
        .instr_o      (instr_out),
        .pred_taken_o (pred_out)
    );

    function automatic int branch_slot(input fetch_pkg::pc_t a);
        if (a == BR_A) begin
            return 0;
        end
        if (a == BR_B) begin
            return 1;
        end
        return -1;
    endfunction

    function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::pc_t a);
        if (branch_slot(a) >= 0) begin
            return {a[26:2], fetch_pkg::OPC_BRANCH};
        end
        return {a[26:2] ^ {18'd0, a[31:27], a[1:0]} ^ 25'h1b4_e27, 7'b0110011};
    endfunction

    // Expected output for a fetch of pc a with the current predictor state
    function automatic out_t ref_output(input fetch_pkg::pc_t a);
        out_t o;
        int   s;
        s       = branch_slot(a);
        o.pc    = a;
        o.instr = mem_word(a);
        o.pred  = 1'b0;
        if (s >= 0) begin
            o.pred = ref_btb[s] && ref_cnt[s][1];
        end
        return o;
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic wait_for_pc(input fetch_pkg::pc_t pc);
        int cnt;
        int start;
        cnt   = 0;
        start = checked;
        while (!(checked > start && last_pc == pc)) begin
            @(posedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                $display("Timed out waiting for an output with pc %h", pc);
                abort_run();
            end
        end
    endtask

    task automatic pulse_redirect(input fetch_pkg::redirect_t mis,
                                  input fetch_pkg::redirect_t jmp,
                                  input fetch_pkg::redirect_t trp);
        mispredict <= mis;
        jump       <= jmp;
        trap_ret   <= trp;
        @(posedge clk);
        mispredict <= '0;
        jump       <= '0;
        trap_ret   <= '0;
    endtask

    task automatic pulse_update(input fetch_pkg::bp_update_t upd);
        bp_update <= upd;
        @(posedge clk);
        bp_update <= '0;
    endtask

    // Compare process sampling mid-cycle
    // Inputs recorded here take effect at the next edge
    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            if (pr_redir.valid) begin
                check_value("bubble on redirect", fetch_pkg::NOP_INSTR, instr_out);
                check_value("no prediction on redirect", 32'd0, {31'd0, pred_out});
                exp_pc = pr_redir.target;
            end else if (pr_stall) begin
                check_value("pc held in stall", held.pc, pc_out);
                check_value("instr held in stall", held.instr, instr_out);
                check_value("pred held in stall", {31'd0, held.pred}, {31'd0, pred_out});
            end else if (instr_out != fetch_pkg::NOP_INSTR) begin
                exp_out = ref_output(exp_pc);
                check_value("pc sequence", exp_out.pc, pc_out);
                check_value("instruction", exp_out.instr, instr_out);
                check_value("prediction", {31'd0, exp_out.pred}, {31'd0, pred_out});
                if (exp_out.pred) begin
                    exp_pc = ref_tgt[branch_slot(exp_pc)];
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
                last_pc = pc_out;
                checked++;
            end
            if (acc) begin
                check_value("line aligned request", {acc_addr[31:4], 4'h0}, acc_addr);
                idx = (acc_addr >> 4) % LINES;
                if (res_valid[idx] && res_line[idx] == acc_addr) begin
                    $display("Line %h was requested again while still cached", acc_addr);
                    abort_run();
                end
                res_valid[idx] = 1'b1;
                res_line[idx]  = acc_addr;
            end
            if (pr_upd.valid) begin
                slot = branch_slot(pr_upd.pc);
                if (pr_upd.taken) begin
                    if (ref_cnt[slot] != 2'b11) begin
                        ref_cnt[slot] = ref_cnt[slot] + 2'b01;
                    end
                    ref_btb[slot] = 1'b1;
                    ref_tgt[slot] = pr_upd.target;
                end else if (ref_cnt[slot] != 2'b00) begin
                    ref_cnt[slot] = ref_cnt[slot] - 2'b01;
                end
            end
        end
        held     = {pc_out, instr_out, pred_out};
        pr_stall = stall;
        pr_upd   = bp_update;
        if (mispredict.valid) begin
            pr_redir = mispredict;
        end else if (jump.valid) begin
            pr_redir = jump;
        end else begin
            pr_redir = trap_ret;
        end
    end

    initial begin
        void'($urandom(32'h5af3));
        checked   = 0;
        exp_pc    = fetch_pkg::RESET_PC;
        last_pc   = '0;
        for (int i = 0; i < 2; i++) begin
            ref_cnt[i] = 2'b01;
            ref_btb[i] = 1'b0;
            ref_tgt[i] = '0;
        end
        for (int i = 0; i < LINES; i++) begin
            res_valid[i] = 1'b0;
            res_line[i]  = '0;
        end
        stall      <= 1'b0;
        mispredict <= '0;
        jump       <= '0;
        trap_ret   <= '0;
        bp_update  <= '0;
        n = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                $display("Reset was never released");
                abort_run();
            end
        end

        // Sequential run and a stall
        wait_for_pc(32'h030);
        stall <= 1'b1;
        repeat (4) @(posedge clk);
        stall <= 1'b0;
        wait_for_pc(32'h040);

        pulse_redirect('0, {1'b1, 32'h180}, '0);
        wait_for_pc(32'h194);
        // Back into resident lines
        pulse_redirect('0, '0, {1'b1, 32'h008});
        wait_for_pc(32'h014);
        pulse_redirect({1'b1, 32'h1a0}, {1'b1, 32'h040}, '0);
        wait_for_pc(32'h1a8);
        pulse_redirect('0, {1'b1, 32'h188}, {1'b1, 32'h000});
        wait_for_pc(32'h190);

        // Redirect while stalled
        stall <= 1'b1;
        @(posedge clk);
        pulse_redirect('0, {1'b1, 32'h030}, '0);
        repeat (3) @(posedge clk);
        stall <= 1'b0;
        wait_for_pc(32'h034);

        // Train BR_A taken, then back to not taken
        pulse_update({1'b1, 1'b1, BR_A, 32'h180});
        pulse_redirect('0, {1'b1, 32'h010}, '0);
        wait_for_pc(32'h184);
        pulse_update({1'b1, 1'b0, BR_A, 32'h000});
        pulse_update({1'b1, 1'b0, BR_A, 32'h000});
        pulse_redirect('0, {1'b1, 32'h020}, '0);
        wait_for_pc(32'h02c);

        pulse_redirect('0, {1'b1, 32'h140}, '0);
        wait_for_pc(32'h14c);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* build.f */
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/branch_predictor.sv
hdl/icache.sv
hdl/icache_ctrl.sv
hdl/fetch_stage.sv
verif/clk_gen.sv
verif/mem_model.sv
verif/fetch_tb.sv
